// ==== Makefile ====
TOP = tb_cart_top

all: run

build:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== hdl/address_map.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module address_map (
  input  snes_map_pkg::snes_addr_u  snes_addr,
  input  snes_map_pkg::mapper_e     mapper,
  input  logic [7:0]                featurebits,
  input  logic [23:0]               rom_mask,
  input  logic [23:0]               saveram_mask,
  output snes_map_pkg::map_result_t result
);
  import snes_map_pkg::*;

  logic [23:0] a;          // Flat view
  logic [7:0]  bank;
  logic [15:0] offset;
  logic        is_rom;
  logic        is_saveram;
  logic        known_map;
  logic [23:0] save_hi;    // HiROM style save offset
  logic [23:0] save_lo;    // LoROM style save offset
  logic [23:0] rom_addr;

  assign a      = snes_addr.flat;
  assign bank   = snes_addr.bo.bank;
  assign offset = snes_addr.bo.offset;

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  // Upper half of banks 40-7F/C0-FF, or 8000-FFFF anywhere
  assign is_rom = bank[6] | offset[15];

  always_comb begin
    known_map  = 1'b1;
    is_saveram = 1'b0;
    case (mapper)
      hirom, exhirom: begin
        // Banks 20-3F and A0-BF, 6000-7FFF
        is_saveram = ~bank[6] & bank[5] & ~offset[15] & (&offset[14:13]);
      end
      lorom: begin
        // Banks 70-7D and F0-FD, low half only on large ROMs
        is_saveram = (&bank[6:4]) & (bank[3:0] < 4'he) & (~offset[15] | ~rom_mask[21]);
      end
      menu:    is_saveram = &bank;
      default: known_map = 1'b0;
    endcase
    is_saveram = is_saveram & saveram_mask[0];  // Zero mask disables save RAM
  end

  //////////////////////////////////////////////////
  // Address packing per mapper
  //////////////////////////////////////////////////

  assign save_hi = {6'd0, bank[4:0], offset[12:0]} & saveram_mask;
  assign save_lo = {4'd0, bank[4:0], offset[14:0]} & saveram_mask;

  always_comb begin
    case (mapper)
      hirom: begin
        rom_addr = is_saveram ? `CART_SAVERAM_BASE + save_hi
                              : {1'b0, a[22:0]} & rom_mask;
      end
      lorom: begin
        rom_addr = is_saveram ? `CART_SAVERAM_BASE + save_lo
                              : {2'b00, a[22:16], a[14:0]} & rom_mask;
      end
      exhirom: begin
        // Banks 00-7F sit above C0-FF
        rom_addr = is_saveram ? `CART_SAVERAM_BASE + save_hi
                              : {1'b0, ~a[23], a[21:0]} & rom_mask;
      end
      menu: begin
        rom_addr = is_saveram ? a
                              : ({1'b0, a[22:0]} & rom_mask) + `CART_MENU_BASE;
      end
      default: rom_addr = 24'd0;
    endcase
  end

  always_comb begin
    result.rom_addr       = rom_addr;
    result.rom_hit        = known_map & (is_rom | is_saveram);
    result.is_rom         = is_rom;
    result.is_saveram     = is_saveram;
    result.is_writable    = is_saveram;  // Only save RAM takes writes
    result.msu_enable     = featurebits[feat_msu1_idx] & ~bank[6]
                            & ((offset & 16'hfff8) == 16'h2000);
    result.srtc_enable    = featurebits[feat_srtc_idx] & ~bank[6]
                            & ((offset & 16'hfffe) == 16'h2800);
    result.snescmd_enable = ~bank[6] & (offset[15:8] == 8'h2a);
  end

endmodule

// ==== hdl/cart_top.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_top (
  input  logic                     clk,
  input  logic                     rst,
  // SNES side
  input  logic [23:0]              snes_addr,
  input  logic                     snes_rd,
  input  logic                     snes_wr,
  input  logic [7:0]               snes_wdata,
  input  logic [2:0]               mapper,
  input  logic [7:0]               featurebits,
  input  logic [23:0]              rom_mask,
  input  logic [23:0]              saveram_mask,
  output logic [7:0]               snes_rdata,
  output logic                     snes_rvalid,
  output logic                     rom_hit,
  output logic                     is_saveram,
  output logic                     msu_enable,
  output logic                     srtc_enable,
  output logic                     snescmd_enable,
  // MCU side
  input  logic [`CART_SRAM_AW-1:0] mcu_addr,
  input  logic [7:0]               mcu_wdata,
  input  logic                     mcu_wr,
  input  logic                     mcu_rd,
  output logic                     mcu_busy,
  output logic                     mcu_wr_done,
  output logic [7:0]               mcu_rdata,
  output logic                     mcu_rvalid
);
  import snes_map_pkg::*;

  snes_addr_u  addr_u;
  mapper_e     mapper_sel;
  map_result_t map;

  mem_req_if snes_req ();
  mem_req_if mcu_req ();

  assign addr_u.flat = snes_addr;
  assign mapper_sel  = mapper_e'(mapper);   // Unknown codes decode to no hit

  address_map i_address_map (
    .snes_addr    (addr_u),
    .mapper       (mapper_sel),
    .featurebits  (featurebits),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .result       (map)
  );

  snes_port i_snes_port (
    .clk         (clk),
    .rst         (rst),
    .snes_rd     (snes_rd),
    .snes_wr     (snes_wr),
    .snes_wdata  (snes_wdata),
    .map         (map),
    .snes_rdata  (snes_rdata),
    .snes_rvalid (snes_rvalid),
    .mem         (snes_req.requester)
  );

  mcu_port i_mcu_port (
    .clk         (clk),
    .rst         (rst),
    .mcu_addr    (mcu_addr),
    .mcu_wdata   (mcu_wdata),
    .mcu_wr      (mcu_wr),
    .mcu_rd      (mcu_rd),
    .mcu_busy    (mcu_busy),
    .mcu_wr_done (mcu_wr_done),
    .mcu_rdata   (mcu_rdata),
    .mcu_rvalid  (mcu_rvalid),
    .mem         (mcu_req.requester)
  );

  sram_ctrl i_sram_ctrl (
    .clk       (clk),
    .rst       (rst),
    .snes_side (snes_req.arbiter),
    .mcu_side  (mcu_req.arbiter)
  );

  // Decode flags straight from the mapper
  assign rom_hit        = map.rom_hit;
  assign is_saveram     = map.is_saveram;
  assign msu_enable     = map.msu_enable;
  assign srtc_enable    = map.srtc_enable;
  assign snescmd_enable = map.snescmd_enable;

endmodule

// ==== hdl/mcu_port.sv ====
`timescale 1ns/1ps

module mcu_port (
  input  logic                     clk,
  input  logic                     rst,
  input  sram_bus_pkg::sram_addr_t mcu_addr,
  input  sram_bus_pkg::sram_data_t mcu_wdata,
  input  logic                     mcu_wr,
  input  logic                     mcu_rd,
  output logic                     mcu_busy,
  output logic                     mcu_wr_done,
  output sram_bus_pkg::sram_data_t mcu_rdata,
  output logic                     mcu_rvalid,
  mem_req_if.requester             mem
);
  import sram_bus_pkg::*;

  logic       take;       // Strobe accepted while idle
  logic       req_q;
  logic       we_q;       // Pending kind, write when high
  logic       wr_done_q;
  sram_addr_t addr_q;
  sram_data_t wdata_q;

  assign take = ~req_q & (mcu_wr | mcu_rd);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q     <= 1'b0;
      we_q      <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      wr_done_q <= req_q & mem.gnt & we_q;
      if (take) begin
        req_q <= 1'b1;
        we_q  <= mcu_wr;        // Write wins over a read in the same cycle
      end else if (mem.gnt) begin
        req_q <= 1'b0;          // Done once the arbiter takes it
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q  <= mcu_addr;
      wdata_q <= mcu_wdata;
    end
  end

  assign mem.req   = req_q;
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign mcu_busy    = req_q;   // Held from capture until the grant
  assign mcu_wr_done = wr_done_q;
  assign mcu_rvalid  = mem.rvalid;
  assign mcu_rdata   = mem.rdata;

endmodule

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
  import sram_bus_pkg::*;

  logic       req;
  logic       we;     // High for write, low for read
  sram_addr_t addr;
  sram_data_t wdata;
  logic       gnt;    // Request taken when req and gnt are high
  sram_data_t rdata;
  logic       rvalid; // Read data, one cycle after the grant

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

// ==== hdl/snes_map_pkg.sv ====
package snes_map_pkg;

  // Mapper codes as detected by the MCU, other codes give no hit
  typedef enum logic [2:0] {
    hirom   = 3'd0,
    lorom   = 3'd1,
    exhirom = 3'd2,
    menu    = 3'd7
  } mapper_e;

  // Bit positions in featurebits
  localparam int feat_srtc_idx = 2;
  localparam int feat_msu1_idx = 3;

  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } snes_bank_off_t;

  // SNES address, seen as bank:offset or as one flat word
  typedef union packed {
    logic [23:0]    flat;
    snes_bank_off_t bo;
  } snes_addr_u;

  typedef struct packed {
    logic [23:0] rom_addr;       // Mapped SRAM address
    logic        rom_hit;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic        msu_enable;
    logic        srtc_enable;
    logic        snescmd_enable;
  } map_result_t;

endpackage

// ==== hdl/snes_port.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module snes_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      snes_rd,
  input  logic                      snes_wr,
  input  sram_bus_pkg::sram_data_t  snes_wdata,
  input  snes_map_pkg::map_result_t map,
  output sram_bus_pkg::sram_data_t  snes_rdata,
  output logic                      snes_rvalid,
  mem_req_if.requester              mem
);
  import sram_bus_pkg::*;

  logic       rd_s1;
  logic       open_s1;   // Read with no hit, answered with open bus
  logic       rd_s2;
  logic       open_s2;
  logic       req_q;
  logic       we_q;
  sram_addr_t addr_q;
  sram_data_t wdata_q;

  //////////////////////////////////////////////////
  // Stage one, mapped request
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_s1   <= 1'b0;
      open_s1 <= 1'b0;
      req_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      rd_s1   <= snes_rd;
      open_s1 <= snes_rd & ~map.rom_hit;
      // Writes outside save RAM are dropped here
      req_q   <= (snes_rd & map.rom_hit) | (snes_wr & ~snes_rd & map.is_writable);
      we_q    <= snes_wr & ~snes_rd;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= map.rom_addr[`CART_SRAM_AW-1:0];
    wdata_q <= snes_wdata;
  end

  assign mem.req   = req_q;  // Always granted
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  //////////////////////////////////////////////////
  // Stage two, lines up with rvalid
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_s2   <= 1'b0;
      open_s2 <= 1'b0;
    end else begin
      rd_s2   <= rd_s1;
      open_s2 <= open_s1;
    end
  end

  assign snes_rvalid = rd_s2;
  assign snes_rdata  = open_s2 ? `CART_OPEN_BUS : mem.rdata;

endmodule

// ==== hdl/sram_bus_pkg.sv ====
`include "cart_defs.svh"

package sram_bus_pkg;

  // Byte wide SRAM, address width set by the defs header
  typedef logic [`CART_SRAM_AW-1:0] sram_addr_t;
  typedef logic [7:0]               sram_data_t;

  // Who owns the SRAM in a given cycle
  typedef enum logic {
    snes = 1'b0,
    mcu  = 1'b1
  } requester_e;

endpackage

// ==== hdl/sram_ctrl.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module sram_ctrl (
  input  logic       clk,
  input  logic       rst,
  mem_req_if.arbiter snes_side,
  mem_req_if.arbiter mcu_side
);
  import sram_bus_pkg::*;

  sram_data_t ram [2**`CART_SRAM_AW];
  sram_data_t rdata_q;
  sram_addr_t acc_addr;
  sram_data_t acc_wdata;
  logic       acc_go;
  logic       acc_we;
  logic       rd_pend_q;   // Read done last cycle
  requester_e owner_q;     // Side that got the last access

  //////////////////////////////////////////////////
  // Fixed priority, SNES first
  //////////////////////////////////////////////////

  assign snes_side.gnt = snes_side.req;
  assign mcu_side.gnt  = mcu_side.req & ~snes_side.req;

  always_comb begin
    if (snes_side.req) begin
      acc_go    = 1'b1;
      acc_we    = snes_side.we;
      acc_addr  = snes_side.addr;
      acc_wdata = snes_side.wdata;
    end else begin
      acc_go    = mcu_side.req;
      acc_we    = mcu_side.we;
      acc_addr  = mcu_side.addr;
      acc_wdata = mcu_side.wdata;
    end
  end

  //////////////////////////////////////////////////
  // Byte array and read return
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (acc_go) begin
      if (acc_we) ram[acc_addr] <= acc_wdata;
      else        rdata_q       <= ram[acc_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      owner_q   <= snes;
    end else begin
      rd_pend_q <= acc_go & ~acc_we;
      if (acc_go) owner_q <= snes_side.req ? snes : mcu;
    end
  end

  assign snes_side.rvalid = rd_pend_q & (owner_q == snes);
  assign mcu_side.rvalid  = rd_pend_q & (owner_q == mcu);
  assign snes_side.rdata  = rdata_q;   // Shared bus, rvalid selects
  assign mcu_side.rdata   = rdata_q;

endmodule

// ==== include/cart_defs.svh ====
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// SRAM address width in bits
`define CART_SRAM_AW 16

`define CART_SAVERAM_BASE 24'hE00000  // Save RAM lives in the top of SRAM
`define CART_MENU_BASE    24'hC00000  // Menu ROM image
`define CART_OPEN_BUS     8'hFF       // Unmapped read data

`endif

// ==== sim/cart_assertions.sv ====
`timescale 1ns/1ps

module cart_assertions (
  input logic clk,
  input logic rst,
  input logic snes_req,
  input logic snes_gnt,
  input logic snes_we,
  input logic snes_rvalid,
  input logic mcu_req,
  input logic mcu_gnt,
  input logic mcu_we,
  input logic mcu_rvalid
);

  int unsigned fail_count = 0;

  // At most one side owns the SRAM
  grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({snes_gnt, mcu_gnt}))
    else begin
      fail_count++;
      $error("Both SRAM sides granted in one cycle");
    end

  // SNES side has top priority
  snes_always_granted: assert property (@(posedge clk) disable iff (rst)
    snes_req |-> snes_gnt)
    else begin
      fail_count++;
      $error("SNES request not granted");
    end

  snes_rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
    snes_rvalid |-> $past(snes_gnt && !snes_we))
    else begin
      fail_count++;
      $error("SNES rvalid without a granted read");
    end

  mcu_rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
    mcu_rvalid |-> $past(mcu_gnt && mcu_req && !mcu_we))
    else begin
      fail_count++;
      $error("MCU rvalid without a granted read");
    end

endmodule

// ==== sim/cart_checker.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_checker (
  input logic                     clk,
  input logic                     rst,
  input logic [23:0]              snes_addr,
  input logic                     snes_rd,
  input logic                     snes_wr,
  input logic [7:0]               snes_wdata,
  input logic [2:0]               mapper,
  input logic [7:0]               featurebits,
  input logic [23:0]              rom_mask,
  input logic [23:0]              saveram_mask,
  input logic [7:0]               snes_rdata,
  input logic                     snes_rvalid,
  input logic                     rom_hit,
  input logic                     is_saveram,
  input logic                     msu_enable,
  input logic                     srtc_enable,
  input logic                     snescmd_enable,
  input logic [`CART_SRAM_AW-1:0] mcu_addr,
  input logic [7:0]               mcu_wdata,
  input logic                     mcu_wr,
  input logic                     mcu_rd,
  input logic                     mcu_busy,
  input logic                     mcu_wr_done,
  input logic [7:0]               mcu_rdata,
  input logic                     mcu_rvalid
);

  int unsigned check_count = 0;
  int unsigned error_count = 0;

  logic [7:0] shadow [2**`CART_SRAM_AW];

  // Reference decode of the current SNES address
  logic [7:0]  bank;
  logic [15:0] off;
  logic        known;
  logic        in_rom;
  logic        m_save;
  logic        m_hit;
  logic        m_msu;
  logic        m_srtc;
  logic        m_cmd;
  logic [23:0] m_addr;

  // SNES pipeline as seen from the pins
  logic                     s1_rd;
  logic                     s1_open;
  logic                     s1_wr;
  logic [`CART_SRAM_AW-1:0] s1_addr;
  logic [7:0]               s1_wdata;
  logic                     s2_rd;
  logic [7:0]               s2_data;
  logic                     rst_q;
  logic [`CART_SRAM_AW-1:0] mcu_pend_addr;
  logic [7:0]               mcu_pend_data;
  logic                     mcu_pend_we;   // Kind of the MCU access in flight

  always_comb begin
    bank   = snes_addr[23:16];
    off    = snes_addr[15:0];
    in_rom = bank[6] || off[15];
    known  = 1'b1;
    m_save = 1'b0;
    case (mapper)
      3'd0, 3'd2: m_save = (bank[6:5] == 2'b01) && off >= 16'h6000 && off <= 16'h7fff;
      3'd1: m_save = bank[6:0] >= 7'h70 && bank[6:0] <= 7'h7d
                     && (off < 16'h8000 || !rom_mask[21]);
      3'd7: m_save = (bank == 8'hff);
      default: known = 1'b0;
    endcase
    m_save = m_save && saveram_mask[0];
    case (mapper)
      3'd0: m_addr = m_save ? `CART_SAVERAM_BASE + ({bank[4:0], off[12:0]} & saveram_mask)
                            : {1'b0, snes_addr[22:0]} & rom_mask;
      3'd1: m_addr = m_save ? `CART_SAVERAM_BASE + ({bank[4:0], off[14:0]} & saveram_mask)
                            : {2'b00, bank[6:0], off[14:0]} & rom_mask;
      3'd2: m_addr = m_save ? `CART_SAVERAM_BASE + ({bank[4:0], off[12:0]} & saveram_mask)
                            : {1'b0, ~bank[7], snes_addr[21:0]} & rom_mask;
      3'd7: m_addr = m_save ? snes_addr
                            : ({1'b0, snes_addr[22:0]} & rom_mask) + `CART_MENU_BASE;
      default: m_addr = 24'd0;
    endcase
    m_hit  = known && (in_rom || m_save);
    m_msu  = featurebits[3] && !bank[6] && off >= 16'h2000 && off <= 16'h2007;
    m_srtc = featurebits[2] && !bank[6] && off >= 16'h2800 && off <= 16'h2801;
    m_cmd  = !bank[6] && off >= 16'h2a00 && off <= 16'h2aff;
  end

  task automatic compare(input string name, input logic [23:0] exp, input logic [23:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Per-cycle comparison
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      s1_rd <= 1'b0;
      s1_wr <= 1'b0;
      s2_rd <= 1'b0;
    end else begin
      if (rst_q) begin  // First cycle out of reset
        compare("reset_snes_rvalid", 24'd0, {23'd0, snes_rvalid});
        compare("reset_mcu_busy", 24'd0, {23'd0, mcu_busy});
        compare("reset_mcu_wr_done", 24'd0, {23'd0, mcu_wr_done});
        compare("reset_mcu_rvalid", 24'd0, {23'd0, mcu_rvalid});
      end
      compare("decode_rom_hit", {23'd0, m_hit}, {23'd0, rom_hit});
      compare("decode_is_saveram", {23'd0, m_save}, {23'd0, is_saveram});
      compare("decode_msu_enable", {23'd0, m_msu}, {23'd0, msu_enable});
      compare("decode_srtc_enable", {23'd0, m_srtc}, {23'd0, srtc_enable});
      compare("decode_snescmd_enable", {23'd0, m_cmd}, {23'd0, snescmd_enable});

      compare("snes_rvalid_latency", {23'd0, s2_rd}, {23'd0, snes_rvalid});
      if (s2_rd && snes_rvalid)
        compare("snes_read_data", {16'd0, s2_data}, {16'd0, snes_rdata});

      // Completion pulse follows the kind that was taken, busy drops with it
      if (mcu_wr_done || mcu_rvalid) begin
        compare("mcu_wr_done_kind", {23'd0, mcu_pend_we}, {23'd0, mcu_wr_done});
        compare("mcu_rvalid_kind", {23'd0, !mcu_pend_we}, {23'd0, mcu_rvalid});
        compare("mcu_busy_at_done", 24'd0, {23'd0, mcu_busy});
      end

      // MCU read was done at the last edge, before any SNES write now
      if (mcu_rvalid)
        compare("mcu_read_data", {16'd0, shadow[mcu_pend_addr]}, {16'd0, mcu_rdata});
      if (mcu_wr_done)
        shadow[mcu_pend_addr] = mcu_pend_data;

      s2_rd   <= s1_rd;
      s2_data <= s1_open ? `CART_OPEN_BUS : shadow[s1_addr];  // SRAM access at this edge
      if (s1_wr)
        shadow[s1_addr] = s1_wdata;

      s1_rd    <= snes_rd;
      s1_open  <= snes_rd && !m_hit;
      s1_wr    <= snes_wr && !snes_rd && m_save;
      s1_addr  <= m_addr[`CART_SRAM_AW-1:0];
      s1_wdata <= snes_wdata;

      if (!mcu_busy && (mcu_wr || mcu_rd)) begin
        mcu_pend_addr <= mcu_addr;
        mcu_pend_data <= mcu_wdata;
        mcu_pend_we   <= mcu_wr;
      end
    end
  end

endmodule

// ==== sim/tb_cart_top.sv ====
`timescale 1ns/1ps
`include "cart_defs.svh"

module tb_cart_top;

  localparam int wait_limit = 1000;
  localparam int blocks     = 16;
  localparam int snes_ops   = 400;
  localparam int mcu_ops    = 300;

  logic                     clk = 1'b0;
  logic                     rst;
  logic [23:0]              snes_addr;
  logic                     snes_rd;
  logic                     snes_wr;
  logic [7:0]               snes_wdata;
  logic [2:0]               mapper;
  logic [7:0]               featurebits;
  logic [23:0]              rom_mask;
  logic [23:0]              saveram_mask;
  logic [7:0]               snes_rdata;
  logic                     snes_rvalid;
  logic                     rom_hit;
  logic                     is_saveram;
  logic                     msu_enable;
  logic                     srtc_enable;
  logic                     snescmd_enable;
  logic [`CART_SRAM_AW-1:0] mcu_addr;
  logic [7:0]               mcu_wdata;
  logic                     mcu_wr;
  logic                     mcu_rd;
  logic                     mcu_busy;
  logic                     mcu_wr_done;
  logic [7:0]               mcu_rdata;
  logic                     mcu_rvalid;

  integer      seed;
  int unsigned stall_count = 0;
  logic [23:0] last_wr_addr = 24'd0;

  cart_top i_dut (.*);

  cart_checker i_checker (.*);

  bind sram_ctrl cart_assertions i_assertions (
    .clk         (clk),
    .rst         (rst),
    .snes_req    (snes_side.req),
    .snes_gnt    (snes_side.gnt),
    .snes_we     (snes_side.we),
    .snes_rvalid (snes_side.rvalid),
    .mcu_req     (mcu_side.req),
    .mcu_gnt     (mcu_side.gnt),
    .mcu_we      (mcu_side.we),
    .mcu_rvalid  (mcu_side.rvalid)
  );

  always #2 clk = ~clk;

  // Biased SNES address, hitting save RAM and register windows often
  function automatic logic [23:0] pick_addr();
    logic [31:0] r;
    logic [31:0] s;
    r = $random(seed);
    s = $random(seed);
    case (r[2:0])
      3'd2:    return {s[7], 2'b01, s[12:8], 3'b011, s[28:16]};     // HiROM save
      3'd3:    return {s[7], 3'b111, s[11:8], s[15:0]};             // LoROM save
      3'd4:    return {8'hff, s[15:0]};
      3'd5:    return {s[7], s[6], s[13:8], 4'h2, s[0], 1'b0, s[1], 1'b0,
                       s[31], 3'd0, s[27:24]};  // 20xx, 22xx, 28xx, 2Axx
      3'd6:    return {s[7:0], 1'b1, s[14:0]};
      3'd7:    return last_wr_addr;
      default: return s[23:0];
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One MCU access, returns once done or after a timeout
  task automatic mcu_access(input logic we, input logic [`CART_SRAM_AW-1:0] addr,
                            input logic [7:0] data);
    int  n;
    bit  done;
    n = 0;
    while (mcu_busy && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (mcu_busy) begin
      stall_count++;
      $display("MCU port stall: busy stayed high before a new access at %0t", $time);
    end
    mcu_addr  = addr;
    mcu_wdata = data;
    mcu_wr    = we;
    mcu_rd    = ~we;
    next_cycle();
    mcu_wr = 1'b0;
    mcu_rd = 1'b0;
    n      = 0;
    done   = 1'b0;
    while (!done && n < wait_limit) begin
      if (mcu_wr_done || mcu_rvalid) done = 1'b1;
      else begin
        next_cycle();
        n++;
      end
    end
    if (!done) begin
      stall_count++;
      $display("MCU port stall: access at %h never completed", addr);
    end
  endtask

  task automatic snes_traffic();
    logic [31:0] r;
    for (int b = 0; b < blocks; b++) begin
      r            = $random(seed);
      mapper       = (r[1:0] == 2'd3) ? 3'd7 : {1'b0, r[1:0]};
      featurebits  = r[15:8];
      rom_mask     = r[17] ? (r[16] ? 24'h3fffff : 24'h1fffff) : 24'hffffff;
      saveram_mask = r[19] ? (r[18] ? 24'h001fff : 24'h007fff) : (r[18] ? 24'h01ffff : 24'h0);
      for (int i = 0; i < snes_ops; i++) begin
        r          = $random(seed);
        snes_addr  = pick_addr();
        snes_wdata = r[15:8];
        snes_rd    = (r[1:0] == 2'd1) || (r[1:0] == 2'd2);
        snes_wr    = (r[1:0] == 2'd3);
        if (snes_wr) last_wr_addr = snes_addr;
        next_cycle();
      end
    end
    snes_rd = 1'b0;
    snes_wr = 1'b0;
  endtask

  task automatic mcu_traffic();
    logic [31:0] r;
    for (int i = 0; i < mcu_ops; i++) begin
      r = $random(seed);
      mcu_access(r[0], r[`CART_SRAM_AW+7:8], r[7:0]);
    end
  endtask

  initial begin
    seed         = 10175;
    rst          = 1'b1;
    snes_addr    = 24'd0;
    snes_rd      = 1'b0;
    snes_wr      = 1'b0;
    snes_wdata   = 8'd0;
    mapper       = 3'd0;
    featurebits  = 8'd0;
    rom_mask     = 24'hffffff;
    saveram_mask = 24'h001fff;
    mcu_addr     = '0;
    mcu_wdata    = 8'd0;
    mcu_wr       = 1'b0;
    mcu_rd       = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    ////////////////////////////////////////////////
    // Load the whole SRAM from the MCU side
    ////////////////////////////////////////////////
    for (int a = 0; a < 2**`CART_SRAM_AW; a++)
      mcu_access(1'b1, a[`CART_SRAM_AW-1:0], 8'($random(seed)));

    ////////////////////////////////////////////////
    // Mixed SNES and MCU traffic
    ////////////////////////////////////////////////
    fork
      snes_traffic();
      mcu_traffic();
    join
    repeat (4) next_cycle();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d, stalls: %0d",
             i_checker.check_count, i_checker.error_count,
             i_dut.i_sram_ctrl.i_assertions.fail_count, stall_count);
    if (i_checker.error_count == 0 && stall_count == 0
        && i_dut.i_sram_ctrl.i_assertions.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/snes_map_pkg.sv
hdl/sram_bus_pkg.sv
hdl/mem_req_if.sv
hdl/address_map.sv
hdl/snes_port.sv
hdl/mcu_port.sv
hdl/sram_ctrl.sv
hdl/cart_top.sv
sim/cart_assertions.sv
sim/cart_checker.sv
sim/tb_cart_top.sv
